//--- tests/mrx_input.txt
# framepol lsbfirst truncate_words idle_gap packet_hex (128 bits, word 0 in the low bits)
# framepol 0 active high, 1 active low; lsbfirst 0 msb beat first; truncate 0 sends all words
0 0 0 3 0123456789abcdeffedcba9876543210
0 0 0 2 a5a5a5a55a5a5a5a0f0f0f0ff0f0f0f0
1 0 0 4 11112222333344445555666677778888
1 0 0 0 deadbeefcafef00d0badc0de12345678
0 1 0 3 fedcba98765432100123456789abcdef
0 1 0 0 8000000100000002000000037fffffff
0 1 0 0 13579bdf2468ace0aaaa5555cccc3333
1 1 0 2 00ff00ff11ee11ee22dd22dd33cc33cc
0 0 0 0 1000000000000000000000000000000f
0 0 0 0 20000000000000000000000000000e0e
0 0 0 0 300000000000000000000000000d0d0d
0 0 0 0 40000000000000000000000000c0c0c0
0 0 0 0 5000000000000000000000000b0b0b0b
0 1 2 3 99999999888888887777777766666666
0 1 0 2 0a0b0c0d0e0f10111213141516171819
1 0 1 2 ffffffffeeeeeeeeddddddddcccccccc
1 0 0 0 6a6b6c6d6e6f70717273747576777879
0 0 0 1 c001d00dbeadfacefeedba5e0ddba11a

//--- tb.f
design/mio_link_pkg.sv
design/mio_core_pkg.sv
design/mrx_io.sv
design/mrx_protocol.sv
design/mrx_fifo.sv
design/mrx.sv
tests/mrx_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the MIO receiver testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module mrx_tb \
   -f tb.f

# Exit status of the simulation is the test result
./obj_dir/Vmrx_tb

//--- tests/mrx_tb.sv
/*
 * MIO receiver testbench
 * File-driven link beats, random core back-pressure and packet checks
 */
module mrx_tb;

   localparam int NMIO      = mio_link_pkg::NMIO_DEFAULT;
   localparam int WORD_W    = 2 * NMIO;
   localparam int NWORDS    = mio_core_pkg::PACKET_W / WORD_W;
   localparam int DRIVE_DLY = 10;

   // DUT pins
   logic                      io_nreset;
   logic                      rx_clk;
   mio_link_pkg::frame_pol_t  framepol;
   mio_link_pkg::beat_order_t lsbfirst;
   logic                      rx_access;
   logic [NMIO-1:0]           rx_packet;
   logic                      core_ready;
   logic                      core_valid;
   mio_core_pkg::packet_t     core_packet;
   logic                      rx_wait;
   logic                      frame_error;

   // One entry per data file record
   mio_link_pkg::frame_pol_t  rec_pol[$];
   mio_link_pkg::beat_order_t rec_order[$];
   int                        rec_trunc[$];
   int                        rec_gap[$];
   mio_core_pkg::packet_t     rec_pkt[$];

   // Scoreboard
   mio_core_pkg::packet_t exp_q[$];
   logic                  exp_err;
   logic                  watch;
   // Last sampled stall and the packet held during it
   logic                  stalled;
   mio_core_pkg::packet_t held_pkt;
   logic [15:0]           lfsr_state;
   logic                  in_frame;
   int                    cycles;
   int                    limit;

   mrx #(
      .NMIO       (NMIO),
      .FIFO_DEPTH (8)
   ) i_mrx (
      .io_nreset   (io_nreset),
      .rx_clk      (rx_clk),
      .framepol    (framepol),
      .lsbfirst    (lsbfirst),
      .rx_access   (rx_access),
      .rx_packet   (rx_packet),
      .core_ready  (core_ready),
      .core_valid  (core_valid),
      .core_packet (core_packet),
      .rx_wait     (rx_wait),
      .frame_error (frame_error)
   );

   //########################################
   //# Helpers
   //########################################

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("SIMULATION FAILED");
      $fatal(1);
   endtask

   task automatic check_packet(input string name, input mio_core_pkg::packet_t exp,
                               input mio_core_pkg::packet_t act);
      if (act !== exp) begin
         abort_run($sformatf("ERROR at time %0t: %s expected %h actual %h",
                             $time, name, exp, act));
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         abort_run($sformatf("ERROR at time %0t: %s expected %b actual %b",
                             $time, name, exp, act));
      end
   endtask

   // Galois form with taps x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   // Ready on one cycle in 16 on average, so the FIFO fills up
   task automatic draw_ready;
      logic b;
      b = 1'b1;
      repeat (4) begin
         lfsr_state = lfsr_step(lfsr_state);
         b = b & lfsr_state[0];
      end
      core_ready = b;
   endtask

   // Pin level of an idle link
   function automatic logic idle_level(input mio_link_pkg::frame_pol_t pol);
      return pol == mio_link_pkg::FRAME_ACTIVE_LOW;
   endfunction

   task automatic next_cycle;
      @(posedge rx_clk);
      #DRIVE_DLY;
   endtask

   task automatic load_records;
      int           fd;
      int           n;
      int           pol;
      int           order;
      int           trunc;
      int           gap;
      logic [127:0] pkt;
      string        line;
      fd = $fopen("tests/mrx_input.txt", "r");
      if (fd == 0) begin
         abort_run("cannot open the stimulus file tests/mrx_input.txt");
      end else begin
         while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            // Lines starting with # are comments
            if (n > 0 && line.getc(0) != "#") begin
               n = $sscanf(line, "%d %d %d %d %h", pol, order, trunc, gap, pkt);
               if (n == 5) begin
                  rec_pol.push_back(mio_link_pkg::frame_pol_t'(pol[0]));
                  rec_order.push_back(mio_link_pkg::beat_order_t'(order[0]));
                  rec_trunc.push_back(trunc);
                  rec_gap.push_back(gap);
                  rec_pkt.push_back(mio_core_pkg::packet_t'(pkt));
               end
            end
         end
         $fclose(fd);
      end
   endtask

   //########################################
   //# Transmitter model
   //########################################

   task automatic send_record(input int i);
      int           idle;
      int           nsend;
      logic [127:0] bits;
      logic [WORD_W-1:0] w;
      idle = rec_gap[i];
      // An open frame must drop before a mode change or a wait
      if (in_frame && idle == 0 &&
          (rx_wait || rec_pol[i] != framepol || rec_order[i] != lsbfirst)) begin
         idle = 1;
      end
      if (!in_frame || idle != 0) begin
         framepol  = rec_pol[i];
         lsbfirst  = rec_order[i];
         rx_access = idle_level(rec_pol[i]);
         in_frame  = 1'b0;
      end
      repeat (idle) next_cycle();
      // New packet only without wait
      while (rx_wait) begin
         next_cycle();
      end
      nsend     = (rec_trunc[i] != 0) ? rec_trunc[i] : NWORDS;
      bits      = rec_pkt[i];
      rx_access = ~idle_level(framepol);
      in_frame  = 1'b1;
      // Word 0 first with two SDR beats per word
      for (int k = 0; k < nsend; k++) begin
         w = bits[k*WORD_W +: WORD_W];
         rx_packet = (lsbfirst == mio_link_pkg::LSB_BEAT_FIRST) ? w[NMIO-1:0] : w[WORD_W-1:NMIO];
         next_cycle();
         rx_packet = (lsbfirst == mio_link_pkg::LSB_BEAT_FIRST) ? w[WORD_W-1:NMIO] : w[NMIO-1:0];
         next_cycle();
      end
      if (rec_trunc[i] == 0) begin
         exp_q.push_back(rec_pkt[i]);
      end else begin
         // Early end of frame sets the error flag two edges later
         rx_access = idle_level(framepol);
         in_frame  = 1'b0;
         next_cycle();
         next_cycle();
         exp_err = 1'b1;
      end
   endtask

   //########################################
   //# Clock, ready and watchdog
   //########################################

   initial begin
      rx_clk = 1'b0;
      forever #50 rx_clk = ~rx_clk;
   end

   initial begin
      @(posedge io_nreset);
      forever begin
         next_cycle();
         draw_ready();
      end
   end

   initial begin
      cycles = 0;
      forever begin
         @(posedge rx_clk);
         cycles++;
         if (cycles > limit) begin
            abort_run("Timeout, the expected packets did not all arrive in time");
         end
      end
   end

   //########################################
   //# Core side monitor
   //########################################

   // Sampled mid cycle away from both edges
   always @(negedge rx_clk) begin
      if (watch) begin
         check_flag("frame_error", exp_err, frame_error);
         if (stalled) begin
            check_flag("core_valid", 1'b1, core_valid);
            check_packet("core_packet", held_pkt, core_packet);
         end
         if (core_valid && core_ready) begin
            if (exp_q.size() == 0) begin
               abort_run("The core received a packet that was never sent");
            end else begin
               check_packet("core_packet", exp_q[0], core_packet);
               void'(exp_q.pop_front());
            end
         end
         stalled  = core_valid && !core_ready;
         held_pkt = core_packet;
      end
   end

   //########################################
   //# Main sequence
   //########################################

   initial begin
      io_nreset  = 1'b0;
      framepol   = mio_link_pkg::FRAME_ACTIVE_HIGH;
      lsbfirst   = mio_link_pkg::MSB_BEAT_FIRST;
      rx_access  = 1'b0;
      rx_packet  = '0;
      core_ready = 1'b0;
      exp_err    = 1'b0;
      watch      = 1'b0;
      stalled    = 1'b0;
      held_pkt   = '0;
      lfsr_state = 16'd23;
      in_frame   = 1'b0;
      load_records();
      limit = 40 * rec_pkt.size() + 200;
      if (rec_pkt.size() == 0) begin
         abort_run("The stimulus file holds no test records");
      end
      repeat (4) @(posedge rx_clk);
      #DRIVE_DLY;
      io_nreset = 1'b1;
      // Past the reset synchronizer
      repeat (3) next_cycle();
      check_flag("core_valid", 1'b0, core_valid);
      check_flag("rx_wait", 1'b0, rx_wait);
      check_flag("frame_error", 1'b0, frame_error);
      watch = 1'b1;
      for (int i = 0; i < rec_pkt.size(); i++) begin
         send_record(i);
      end
      rx_access = idle_level(framepol);
      in_frame  = 1'b0;
      while (exp_q.size() != 0) begin
         next_cycle();
      end
      // Quiet tail to catch stray packets
      repeat (20) next_cycle();
      // FIFO drained and wait released
      check_flag("core_valid", 1'b0, core_valid);
      check_flag("rx_wait", 1'b0, rx_wait);
      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

//--- design/mrx.sv
/*
 * MIO receiver top level
 * Pin capture, packet assembly and packet FIFO on rx_clk
 */
module mrx #(
   parameter int NMIO       = mio_link_pkg::NMIO_DEFAULT,
   parameter int FIFO_DEPTH = 8
) (
   input  logic                      io_nreset,
   input  logic                      rx_clk,
   input  mio_link_pkg::frame_pol_t  framepol,
   input  mio_link_pkg::beat_order_t lsbfirst,
   input  logic                      rx_access,
   input  logic [NMIO-1:0]           rx_packet,
   input  logic                      core_ready,
   output logic                      core_valid,
   output mio_core_pkg::packet_t     core_packet,
   output logic                      rx_wait,
   output logic                      frame_error
);

   // Capture to assembler
   logic                  sync_nreset;
   logic                  frame;
   logic                  word_valid;
   logic [2*NMIO-1:0]     word;
   // Assembler to FIFO
   logic                  pkt_valid;
   mio_core_pkg::packet_t pkt;

   //########################################
   //# Pin capture
   //########################################

   mrx_io #(
      .NMIO (NMIO)
   ) i_mrx_io (
      .io_nreset   (io_nreset),
      .rx_clk      (rx_clk),
      .framepol    (framepol),
      .lsbfirst    (lsbfirst),
      .rx_access   (rx_access),
      .rx_packet   (rx_packet),
      .sync_nreset (sync_nreset),
      .frame       (frame),
      .word_valid  (word_valid),
      .word        (word)
   );

   //########################################
   //# Packet assembly
   //########################################

   mrx_protocol #(
      .NMIO (NMIO)
   ) i_mrx_protocol (
      .rx_clk      (rx_clk),
      .sync_nreset (sync_nreset),
      .frame       (frame),
      .word_valid  (word_valid),
      .word        (word),
      .pkt_valid   (pkt_valid),
      .pkt         (pkt),
      .frame_error (frame_error)
   );

   //########################################
   //# Packet buffer
   //########################################

   // Room is guaranteed by rx_wait, ready checked inside
   mrx_fifo #(
      .DEPTH     (FIFO_DEPTH),
      .payload_t (mio_core_pkg::packet_t)
   ) i_mrx_fifo (
      .rx_clk      (rx_clk),
      .sync_nreset (sync_nreset),
      .in_valid    (pkt_valid),
      .in_data     (pkt),
      .out_ready   (core_ready),
      .in_ready    (),
      .out_valid   (core_valid),
      .out_data    (core_packet),
      .almost_full (rx_wait)
   );

endmodule

//--- design/mrx_fifo.sv
/*
 * Synchronous packet FIFO
 * Valid/ready output register and registered almost-full wait
 */
module mrx_fifo #(
   parameter int  DEPTH     = 8,
   parameter type payload_t = logic [7:0]
) (
   input  logic     rx_clk,
   input  logic     sync_nreset,
   input  logic     in_valid,
   input  payload_t in_data,
   input  logic     out_ready,
   output logic     in_ready,
   output logic     out_valid,
   output payload_t out_data,
   output logic     almost_full
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   // Storage, output register excluded
   payload_t         mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic [CNT_W-1:0] count_next;
   logic             wr_en;
   logic             rd_en;

   //########################################
   //# Pointers and occupancy
   //########################################

   assign in_ready = (count != CNT_W'(DEPTH));
   assign wr_en    = in_valid & in_ready;
   // Refill output when empty or being taken
   assign rd_en    = (count != '0) & (~out_valid | out_ready);

   assign count_next = count + CNT_W'(wr_en) - CNT_W'(rd_en);

   always_ff @(posedge rx_clk or negedge sync_nreset) begin
      if (!sync_nreset) begin
         wr_ptr      <= '0;
         rd_ptr      <= '0;
         count       <= '0;
         out_valid   <= 1'b0;
         almost_full <= 1'b0;
      end else begin
         if (wr_en) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         count <= count_next;
         // Hold valid until the core takes the entry
         if (rd_en) begin
            out_valid <= 1'b1;
         end else if (out_ready) begin
            out_valid <= 1'b0;
         end
         // Two or fewer free slots
         almost_full <= (DEPTH - int'(count_next)) <= 2;
      end
   end

   //########################################
   //# Data path
   //########################################

   always_ff @(posedge rx_clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= in_data;
      end
      if (rd_en) begin
         out_data <= mem[rd_ptr];
      end
   end

   //########################################
   //# Checks
   //########################################

   // Upstream has no stall, wait must keep room
   a_no_overflow : assert property (
      @(posedge rx_clk) disable iff (!sync_nreset)
      in_valid |-> in_ready
   ) else $error("packet written into full FIFO");

   // Output held while stalled
   a_out_stable : assert property (
      @(posedge rx_clk) disable iff (!sync_nreset)
      out_valid && !out_ready |=> out_valid && $stable(out_data)
   ) else $error("out_data changed under back-pressure");

endmodule

//--- design/mrx_protocol.sv
/*
 * MIO receive packet assembler
 * Collects link words into packets and drops frames cut short
 */
module mrx_protocol #(
   parameter int NMIO = 16
) (
   input  logic                 rx_clk,
   input  logic                 sync_nreset,
   input  logic                 frame,
   input  logic                 word_valid,
   input  logic [2*NMIO-1:0]    word,
   output logic                 pkt_valid,
   output mio_core_pkg::packet_t pkt,
   output logic                 frame_error
);

   // Link word size and words per packet
   localparam int WORD_W = 2 * NMIO;
   localparam int NWORDS = mio_core_pkg::PACKET_W / WORD_W;
   // Counter needs one bit even for single word packets
   localparam int CNT_W  = (NWORDS > 1) ? $clog2(NWORDS) : 1;

   // Word position inside the packet being built
   logic [CNT_W-1:0]                  cnt;
   // Frame from the previous cycle
   logic                              frame_q;
   // Falling frame edge
   logic                              frame_fall;
   // Packet under assembly
   logic [mio_core_pkg::PACKET_W-1:0] pkt_q;

   //########################################
   //# Elaboration checks
   //########################################

   // Words must tile the packet exactly
   if ((64 % NMIO) != 0) begin : g_nmio_check
      $error("NMIO must divide 64");
   end

   if (mio_core_pkg::PACKET_T_W != mio_core_pkg::PACKET_W) begin : g_layout_check
      $error("packet_t does not match PACKET_W");
   end

   //########################################
   //# Word counter and error
   //########################################

   assign frame_fall = frame_q & ~frame;

   always_ff @(posedge rx_clk or negedge sync_nreset) begin
      if (!sync_nreset) begin
         cnt         <= '0;
         frame_q     <= 1'b0;
         pkt_valid   <= 1'b0;
         frame_error <= 1'b0;
      end else begin
         frame_q   <= frame;
         pkt_valid <= 1'b0;
         if (word_valid) begin
            // Last word closes the packet
            if (cnt == CNT_W'(NWORDS - 1)) begin
               cnt       <= '0;
               pkt_valid <= 1'b1;
            end else begin
               cnt <= cnt + 1'b1;
            end
         end else if (frame_fall && (cnt != '0)) begin
            // Truncated frame, partial packet thrown away
            cnt         <= '0;
            frame_error <= 1'b1;
         end
      end
   end

   //########################################
   //# Packet register
   //########################################

   // Fill from the low word upward
   always_ff @(posedge rx_clk) begin
      if (word_valid) begin
         pkt_q[cnt*WORD_W +: WORD_W] <= word;
      end
   end

   // Stable for the pkt_valid cycle, next word is two cycles away
   assign pkt = mio_core_pkg::packet_t'(pkt_q);

endmodule

//--- design/mrx_io.sv
/*
 * MIO receive pin capture
 * Reset sync, frame polarity and pairing of SDR beats into link words
 */
module mrx_io #(
   parameter int NMIO = 16
) (
   input  logic                      io_nreset,
   input  logic                      rx_clk,
   input  mio_link_pkg::frame_pol_t  framepol,
   input  mio_link_pkg::beat_order_t lsbfirst,
   input  logic                      rx_access,
   input  logic [NMIO-1:0]           rx_packet,
   output logic                      sync_nreset,
   output logic                      frame,
   output logic                      word_valid,
   output logic [2*NMIO-1:0]         word
);

   // Reset synchronizer stages
   logic [1:0]      rsync;
   // Frame after polarity fix straight from the pin
   logic            rx_frame;
   // High when the next beat closes a word
   logic            second_beat;
   // Held first beat of the current word
   logic [NMIO-1:0] first_beat;

   //########################################
   //# Reset
   //########################################

   // Assert at once and release on second edge
   always_ff @(posedge rx_clk or negedge io_nreset) begin
      if (!io_nreset) begin
         rsync <= 2'b00;
      end else begin
         rsync <= {rsync[0], 1'b1};
      end
   end

   assign sync_nreset = rsync[1];

   //########################################
   //# Frame polarity
   //########################################

   // Invert pin for active low framing
   assign rx_frame = rx_access ^ (framepol == mio_link_pkg::FRAME_ACTIVE_LOW);

   //########################################
   //# Beat pairing
   //########################################

   // Beat select restarts on first beat whenever the frame drops,
   // so an unpaired first beat is simply forgotten
   always_ff @(posedge rx_clk or negedge sync_nreset) begin
      if (!sync_nreset) begin
         frame       <= 1'b0;
         second_beat <= 1'b0;
         word_valid  <= 1'b0;
      end else begin
         frame       <= rx_frame;
         second_beat <= rx_frame & ~second_beat;
         // One cycle strobe after the closing beat
         word_valid  <= rx_frame & second_beat;
      end
   end

   // Word halves steered by beat order
   always_ff @(posedge rx_clk) begin
      if (rx_frame && !second_beat) begin
         first_beat <= rx_packet;
      end
      if (rx_frame && second_beat) begin
         if (lsbfirst == mio_link_pkg::LSB_BEAT_FIRST) begin
            word <= {rx_packet, first_beat};
         end else begin
            word <= {first_beat, rx_packet};
         end
      end
   end

   //########################################
   //# Checks
   //########################################

   // Both beats of a word come from one open frame
   a_word_in_frame : assert property (
      @(posedge rx_clk) disable iff (!sync_nreset)
      $rose(word_valid) |-> frame && $past(frame)
   ) else $error("word_valid rose outside a frame");

endmodule

//--- design/mio_core_pkg.sv
/*
 * MIO core-side definitions
 * Packet layout handed from the receive FIFO to the core
 */
package mio_core_pkg;

   //########################################
   //# Packet geometry
   //########################################

   // Fixed packet size on the link
   localparam int PACKET_W = 128;

   //########################################
   //# Packet layout
   //########################################

   // Word 0 on the link lands in the lowest bits,
   // so srcaddr arrives first and ctrl last
   typedef struct packed {
      // Command and transaction type
      logic [7:0]  ctrl;
      // Destination address
      logic [23:0] dstaddr;
      // Payload
      logic [63:0] data;
      // Source address
      logic [31:0] srcaddr;
   } packet_t;

   // Layout has to fill the packet exactly
   localparam int PACKET_T_W = $bits(packet_t);

endpackage

//--- design/mio_link_pkg.sv
/*
 * MIO link-side definitions
 * Frame polarity, beat order and default pin count
 */
package mio_link_pkg;

   //########################################
   //# Bus geometry
   //########################################

   // Data pins driven by the transmitter
   localparam int NMIO_DEFAULT = 16;

   //########################################
   //# Link modes
   //########################################

   // Level of rx_access that marks an active frame
   typedef enum logic {
      FRAME_ACTIVE_HIGH = 1'b0,
      FRAME_ACTIVE_LOW  = 1'b1
   } frame_pol_t;

   // Which half of a link word the first SDR beat fills
   typedef enum logic {
      MSB_BEAT_FIRST = 1'b0,   // first beat -> high half
      LSB_BEAT_FIRST = 1'b1    // first beat -> low half
   } beat_order_t;

endpackage
